//--- project.f
+incdir+hdl
hdl/cache_pkg.sv
hdl/line_store_if.sv
hdl/cache_fsm.sv
hdl/burst_sequencer.sv
hdl/line_store.sv
hdl/data_cache.sv
verification/burst_ram_model.sv
verification/data_cache_tb.sv

//--- Makefile
# Verilator build and run of the data cache testbench

TOP = data_cache_tb

.PHONY: sim clean

sim:
	verilator --binary -j 0 -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- verification/cache_trace.txt
# op (0 read, 1 write), byte address, write data, byte enables, expected read word
# all values hex, preset RAM word is its byte address xor c0de0000
0 00000040 00000000 0 c0de0040
0 00000044 00000000 0 c0de0044
1 00000048 aabbccdd 3 00000000
0 00000048 00000000 0 c0deccdd
0 000000c0 00000000 0 c0de00c0
0 00000048 00000000 0 c0deccdd
1 00000060 11223344 c 00000000
0 00000060 00000000 0 11220060
0 00000064 00000000 0 c0de0064
0 00000100 00000000 0 c0de0100
0 00000104 00000000 0 c0de0104
0 00000108 00000000 0 c0de0108
0 0000010c 00000000 0 c0de010c
0 00000110 00000000 0 c0de0110
0 00000114 00000000 0 c0de0114
0 00000118 00000000 0 c0de0118
0 0000011c 00000000 0 c0de011c
0 000007e0 00000000 0 c0de07e0
0 00000060 00000000 0 11220060

//--- verification/data_cache_tb.sv
// trace-driven testbench of the data cache
// startup check, per-entry read and write checks, timeout counter

`timescale 1ns/1ps

module data_cache_tb;
  logic        clk;
  logic        rst;
  logic        enable;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [3:0]  write_enable_bytes;
  logic [31:0] data_out;
  logic        data_out_valid;
  logic        busy;
  logic        br_cmd;
  logic        br_cmd_en;
  logic [7:0]  br_addr;
  logic [63:0] br_wr_data;
  logic [7:0]  br_data_mask;
  logic [63:0] br_rd_data;
  logic        br_rd_data_valid;
  logic        br_busy;

  // trace columns
  logic [31:0] t_op [$];
  logic [31:0] t_addr [$];
  logic [31:0] t_data [$];
  logic [31:0] t_be [$];
  logic [31:0] t_exp [$];

  // expected line state, two lines picked by address bit 5
  logic        exp_valid [2];
  logic [25:0] exp_tag [2];

  int errors;
  int tests;
  int cycles;
  int limit;

  data_cache u_data_cache (
    .clk                (clk),
    .rst                (rst),
    .enable             (enable),
    .address            (address),
    .data_in            (data_in),
    .write_enable_bytes (write_enable_bytes),
    .data_out           (data_out),
    .data_out_valid     (data_out_valid),
    .busy               (busy),
    .br_cmd             (br_cmd),
    .br_cmd_en          (br_cmd_en),
    .br_addr            (br_addr),
    .br_wr_data         (br_wr_data),
    .br_data_mask       (br_data_mask),
    .br_rd_data         (br_rd_data),
    .br_rd_data_valid   (br_rd_data_valid),
    .br_busy            (br_busy)
  );

  burst_ram_model u_ram (
    .clk       (clk),
    .cmd       (br_cmd),
    .cmd_en    (br_cmd_en),
    .addr      (br_addr),
    .wr_data   (br_wr_data),
    .data_mask (br_data_mask),
    .rd_data   (br_rd_data),
    .rd_valid  (br_rd_data_valid),
    .busy      (br_busy)
  );

  always #10 clk = ~clk;

  // run limit from the trace length
  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // every RAM command carries whole beats
  always @(negedge clk) begin
    if (br_cmd_en && (br_data_mask !== 8'hff)) begin
      $display("[ERROR] %0t: command mask %h expected ff", $time, br_data_mask);
      errors++;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic load_trace();
    int    fd;
    int    n;
    string line;
    logic [31:0] op, a, d, b, e;
    fd = $fopen("verification/cache_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file");
      errors++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        // skip comment and blank lines
        if (line.len() == 0 || line.substr(0, 0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%h %h %h %h %h", op, a, d, b, e);
        if (n == 5) begin
          t_op.push_back(op);
          t_addr.push_back(a);
          t_data.push_back(d);
          t_be.push_back(b);
          t_exp.push_back(e);
        end
      end
      $fclose(fd);
      if (t_op.size() == 0) begin
        $display("the trace file held no operations");
        errors++;
      end
    end
  endtask

  // busy must stay high until the RAM reports ready
  task automatic check_startup();
    int   bad;
    logic prev_br_busy;
    bad = errors;
    if (busy !== 1'b1) begin
      $display("busy was not high right after reset");
      errors++;
    end
    if (data_out_valid !== 1'b0) begin
      $display("data_out_valid was high right after reset");
      errors++;
    end
    prev_br_busy = br_busy;
    while (busy) begin
      if (br_cmd_en) begin
        $display("command issued during startup");
        errors++;
      end
      prev_br_busy = br_busy;
      next_cycle();
    end
    if (prev_br_busy) begin
      $display("busy fell while the RAM was still busy");
      errors++;
    end
    tests++;
    $display("startup: %s", (errors == bad) ? "ok" : "failed");
  endtask

  task automatic run_entry(input int i);
    int          bad;
    logic        is_read;
    logic        line_sel;
    logic        exp_hit;
    logic        got_valid;
    logic [31:0] got;
    bad     = errors;
    is_read = (t_op[i] == 32'd0);
    // tag is everything above the line bit
    line_sel = t_addr[i][5];
    exp_hit  = exp_valid[line_sel] && (exp_tag[line_sel] == t_addr[i][31:6]);
    enable             = 1'b1;
    address            = t_addr[i];
    data_in            = t_data[i];
    write_enable_bytes = t_be[i][3:0];
    next_cycle();
    enable    = 1'b0;
    got_valid = data_out_valid;
    got       = data_out;
    // busy stays low on a hit and rises one cycle after enable on a miss
    if (exp_hit && busy) begin
      $display("hit on %h raised busy", t_addr[i]);
      errors++;
    end else if (!exp_hit && !busy) begin
      $display("miss on %h did not raise busy", t_addr[i]);
      errors++;
    end
    // on a miss wait for busy to fall
    if (!got_valid && busy) begin
      while (busy) begin
        next_cycle();
      end
      got_valid = data_out_valid;
      got       = data_out;
    end
    if (is_read) begin
      if (!got_valid) begin
        $display("read of %h finished without returning data", t_addr[i]);
        errors++;
      end else if (got != t_exp[i]) begin
        $display("[ERROR] %0t: read %h got %h expected %h", $time, t_addr[i], got, t_exp[i]);
        errors++;
      end
    end else if (got_valid) begin
      $display("write to %h produced a read response", t_addr[i]);
      errors++;
    end
    // the line now holds the requested tag
    exp_valid[line_sel] = 1'b1;
    exp_tag[line_sel]   = t_addr[i][31:6];
    tests++;
    $display("entry %0d %s %h: %s", i, is_read ? "read" : "write", t_addr[i],
             (errors == bad) ? "ok" : "failed");
  endtask

  initial begin
    clk                = 1'b0;
    rst                = 1'b1;
    enable             = 1'b0;
    address            = '0;
    data_in            = '0;
    write_enable_bytes = '0;
    errors             = 0;
    tests              = 0;
    cycles             = 0;
    limit              = 0;
    exp_valid[0]       = 1'b0;
    exp_valid[1]       = 1'b0;
    load_trace();
    limit = 60 * t_op.size() + 100;
    repeat (4) next_cycle();
    rst = 1'b0;
    check_startup();
    for (int i = 0; i < t_op.size(); i++) begin
      run_entry(i);
    end
    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- verification/burst_ram_model.sv
// behavioral burst RAM, 256 beats of 64 bits
// preset pattern, startup busy, random read latency with single-cycle gaps

`timescale 1ns/1ps

module burst_ram_model (
  input  logic        clk,
  input  logic        cmd,
  input  logic        cmd_en,
  input  logic [7:0]  addr,
  input  logic [63:0] wr_data,
  input  logic [7:0]  data_mask,
  output logic [63:0] rd_data,
  output logic        rd_valid,
  output logic        busy
);
  logic [63:0] mem [256];
  logic [31:0] byte_addr;
  logic [7:0]  wr_ptr;
  logic [7:0]  rd_ptr;
  logic        gapped;
  integer      seed;
  int          startup;
  int          wr_left;
  int          rd_left;
  int          rd_delay;

  initial begin
    seed = 32'h57b3aeb2;
    // each word holds its own byte address xor c0de0000
    for (int b = 0; b < 256; b++) begin
      byte_addr = 32'(b) << 3;
      mem[b] = {(byte_addr + 32'd4) ^ 32'hc0de0000, byte_addr ^ 32'hc0de0000};
    end
    busy     = 1'b1;
    rd_valid = 1'b0;
    rd_data  = '0;
    startup  = 0;
    wr_left  = 0;
    rd_left  = 0;
    rd_delay = 0;
    wr_ptr   = '0;
    rd_ptr   = '0;
    gapped   = 1'b0;
  end

  always @(posedge clk) begin
    rd_valid <= 1'b0;
    // busy for the first 6 cycles of the run
    if (startup < 6) begin
      startup <= startup + 1;
    end
    busy <= (startup < 5);
    // write burst, beat 0 rides with the command
    if (cmd_en && cmd && (data_mask != 8'h00)) begin
      mem[addr] <= wr_data;
      wr_ptr    <= addr + 8'd1;
      wr_left   <= 3;
    end else if (wr_left > 0) begin
      mem[wr_ptr] <= wr_data;
      wr_ptr      <= wr_ptr + 8'd1;
      wr_left     <= wr_left - 1;
    end
    // read burst
    if (cmd_en && !cmd) begin
      rd_ptr   <= addr;
      rd_left  <= 4;
      rd_delay <= $random(seed) & 3;
      gapped   <= 1'b0;
    end else if (rd_left > 0) begin
      if (rd_delay > 0) begin
        rd_delay <= rd_delay - 1;
      end else if (!gapped && (($random(seed) & 3) == 0)) begin
        // one idle cycle, never two in a row
        gapped <= 1'b1;
      end else begin
        rd_data  <= mem[rd_ptr];
        rd_valid <= 1'b1;
        rd_ptr   <= rd_ptr + 8'd1;
        rd_left  <= rd_left - 1;
        gapped   <= 1'b0;
      end
    end
  end

endmodule

//--- hdl/data_cache.sv
// data cache top level
// direct-mapped write-back cache with write-allocate in front of a burst RAM
// FSM, burst sequencer and line store joined by the line store interface

`timescale 1ns/1ps
`include "cache_config.svh"

module data_cache (
  input  logic                         clk,
  input  logic                         rst,
  // core side
  input  logic                         enable,
  input  logic [`CACHE_ADDR_W-1:0]     address,
  input  logic [`CACHE_DATA_W-1:0]     data_in,
  input  logic [`CACHE_BE_W-1:0]       write_enable_bytes,
  output logic [`CACHE_DATA_W-1:0]     data_out,
  output logic                         data_out_valid,
  output logic                         busy,
  // burst RAM side
  output logic                         br_cmd,
  output logic                         br_cmd_en,
  output logic [`CACHE_RAM_ADDR_W-1:0] br_addr,
  output logic [`CACHE_BURST_W-1:0]    br_wr_data,
  output logic [`CACHE_BURST_W/8-1:0]  br_data_mask,
  input  logic [`CACHE_BURST_W-1:0]    br_rd_data,
  input  logic                         br_rd_data_valid,
  input  logic                         br_busy
);
  import cache_pkg::*;

  cache_addr_u req_addr;
  logic        last;
  logic        seq_start;
  logic        seq_read;

  line_store_if ls_if ();

  assign req_addr.raw = address;
  // whole beats every time
  assign br_data_mask = '1;

  cache_fsm u_fsm (
    .clk            (clk),
    .rst            (rst),
    .enable         (enable),
    .req_addr       (req_addr),
    .be             (write_enable_bytes),
    .br_busy        (br_busy),
    .last           (last),
    .ls             (ls_if.ctrl),
    .busy           (busy),
    .data_out_valid (data_out_valid),
    .br_cmd         (br_cmd),
    .br_cmd_en      (br_cmd_en),
    .br_addr        (br_addr),
    .seq_start      (seq_start),
    .seq_read       (seq_read)
  );

  burst_sequencer u_seq (
    .clk      (clk),
    .rst      (rst),
    .start    (seq_start),
    .read     (seq_read),
    .rd_valid (br_rd_data_valid),
    .last     (last),
    .ls       (ls_if.seq)
  );

  line_store u_store (
    .clk        (clk),
    .rst        (rst),
    .ls         (ls_if.store),
    .req_addr   (req_addr),
    .data_in    (data_in),
    .be         (write_enable_bytes),
    .br_rd_data (br_rd_data),
    .br_wr_data (br_wr_data),
    .data_out   (data_out)
  );

endmodule

//--- hdl/line_store.sv
// line store of the data cache
// valid, dirty and tag per line, line words
// beat packing toward the RAM, beat unpacking and byte merge

`timescale 1ns/1ps
`include "cache_config.svh"

module line_store (
  input  logic                      clk,
  input  logic                      rst,
  line_store_if.store               ls,
  input  cache_pkg::cache_addr_u    req_addr,
  input  logic [`CACHE_DATA_W-1:0]  data_in,
  input  logic [`CACHE_BE_W-1:0]    be,
  input  logic [`CACHE_BURST_W-1:0] br_rd_data,
  output logic [`CACHE_BURST_W-1:0] br_wr_data,
  output logic [`CACHE_DATA_W-1:0]  data_out
);
  import cache_pkg::*;

  localparam int LINES          = 1 << `CACHE_LINE_IX_W;
  localparam int WORDS          = 1 << `CACHE_WORD_IX_W;
  localparam int WORDS_PER_BEAT = `CACHE_BURST_W / `CACHE_DATA_W;
  // low word index bits select the word inside a beat
  localparam int SUB_W          = `CACHE_WORD_IX_W - $bits(beat_ix_t);

  logic [LINES-1:0]            valid_q;
  logic [LINES-1:0]            dirty_q;
  logic [`CACHE_TAG_W-1:0]     tags [LINES];
  logic [`CACHE_DATA_W-1:0]    words [LINES][WORDS];
  logic [`CACHE_WORD_IX_W-1:0] word_ix;

  assign word_ix = req_addr.fields.word_ix;

  // lookup
  assign ls.hit        = valid_q[ls.line_ix] && (tags[ls.line_ix] == req_addr.fields.tag);
  // dirty is only ever set on a valid line
  assign ls.dirty      = dirty_q[ls.line_ix];
  assign ls.victim_tag = tags[ls.line_ix];

  // outgoing beat, lowest word in the low half
  for (genvar g = 0; g < WORDS_PER_BEAT; g++) begin : g_pack
    assign br_wr_data[g*`CACHE_DATA_W +: `CACHE_DATA_W] =
        words[ls.line_ix][{ls.beat_ix, SUB_W'(g)}];
  end

  // word storage
  always_ff @(posedge clk) begin
    if (ls.fill_we) begin
      // split the beat into its words
      for (int w = 0; w < WORDS_PER_BEAT; w++) begin
        words[ls.line_ix][{ls.beat_ix, SUB_W'(w)}] <=
            br_rd_data[w*`CACHE_DATA_W +: `CACHE_DATA_W];
      end
    end
    if (ls.merge_we) begin
      // only the enabled byte lanes change
      for (int b = 0; b < `CACHE_BE_W; b++) begin
        if (be[b]) begin
          words[ls.line_ix][word_ix][b*8 +: 8] <= data_in[b*8 +: 8];
        end
      end
    end
    // read port, sampled every cycle
    data_out <= words[ls.line_ix][word_ix];
  end

  // tag of the line being allocated
  always_ff @(posedge clk) begin
    if (ls.tag_we) begin
      tags[ls.line_ix] <= req_addr.fields.tag;
    end
  end

  // line state
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (ls.tag_we) begin
      // fresh line matches the RAM
      valid_q[ls.line_ix] <= 1'b1;
      dirty_q[ls.line_ix] <= 1'b0;
    end else if (ls.merge_we) begin
      dirty_q[ls.line_ix] <= 1'b1;
    end
  end

endmodule

//--- hdl/burst_sequencer.sv
// burst beat counter
// paces write-back beats every cycle and fill beats on read valid

`timescale 1ns/1ps
`include "cache_config.svh"

module burst_sequencer (
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  logic      read,
  input  logic      rd_valid,
  output logic      last,
  line_store_if.seq ls
);
  import cache_pkg::*;

  logic     active;
  logic     rd_mode;
  logic     step;
  logic     final_beat;
  beat_ix_t base_ix;

  // a write burst already sends beat 0 with the command
  always_comb begin
    if (start) begin
      step = !read;
    end else begin
      step = active && (!rd_mode || rd_valid);
    end
  end

  // count restarts on every new burst
  assign base_ix    = start ? '0 : ls.beat_ix;
  assign final_beat = step && (base_ix == beat_ix_t'(`CACHE_BURST_LEN - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      active     <= 1'b0;
      rd_mode    <= 1'b0;
      ls.beat_ix <= '0;
      last       <= 1'b0;
    end else begin
      // wraps back to beat 0 after the final beat
      ls.beat_ix <= base_ix + beat_ix_t'(step);
      last       <= final_beat;
      if (start) begin
        active  <= 1'b1;
        rd_mode <= read;
      end else if (final_beat) begin
        active <= 1'b0;
      end
    end
  end

endmodule

//--- hdl/cache_fsm.sv
// cache controller FSM
// lookup, victim write-back, line fill and request completion

`timescale 1ns/1ps
`include "cache_config.svh"

module cache_fsm (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         enable,
  input  cache_pkg::cache_addr_u       req_addr,
  input  logic [`CACHE_BE_W-1:0]       be,
  input  logic                         br_busy,
  input  logic                         last,
  line_store_if.ctrl                   ls,
  output logic                         busy,
  output logic                         data_out_valid,
  output logic                         br_cmd,
  output logic                         br_cmd_en,
  output logic [`CACHE_RAM_ADDR_W-1:0] br_addr,
  output logic                         seq_start,
  output logic                         seq_read
);
  import cache_pkg::*;

  cache_state_e             state;
  logic                     is_write;
  cache_addr_u              wb_line;
  logic [`CACHE_ADDR_W-1:0] wb_beat;
  logic [`CACHE_ADDR_W-1:0] fill_beat;

  // no byte enables means read
  assign is_write = |be;
  // lookup always follows the request, held stable while busy
  assign ls.line_ix = req_addr.fields.line_ix;

  // victim line base rebuilt from the stored tag
  always_comb begin
    wb_line.fields.tag     = ls.victim_tag;
    wb_line.fields.line_ix = req_addr.fields.line_ix;
    wb_line.fields.word_ix = '0;
    wb_line.fields.align   = '0;
  end

  assign wb_beat = wb_line.raw >> `CACHE_BEAT_SHIFT;
  // requested line base, word and byte bits cleared
  assign fill_beat = {req_addr.raw[`CACHE_ADDR_W-1:`CACHE_WORD_IX_W+`CACHE_ALIGN_W],
                      {(`CACHE_WORD_IX_W + `CACHE_ALIGN_W){1'b0}}} >> `CACHE_BEAT_SHIFT;

  // write hit merges right away, a write miss merges after the fill
  assign ls.merge_we = ((state == idle) && enable && ls.hit && is_write) ||
                       ((state == finish) && is_write);
  // beats land while filling, last marks the burst as done
  assign ls.fill_we = (state == fill) && !last;
  assign ls.tag_we  = (state == fill) && last;

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= wait_ram;
      busy           <= 1'b1;
      data_out_valid <= 1'b0;
      br_cmd_en      <= 1'b0;
      seq_start      <= 1'b0;
    end else begin
      // single cycle pulses
      data_out_valid <= 1'b0;
      br_cmd_en      <= 1'b0;
      seq_start      <= 1'b0;
      case (state)
        wait_ram: begin
          if (!br_busy) begin
            busy  <= 1'b0;
            state <= idle;
          end
        end
        idle: begin
          if (enable) begin
            if (ls.hit) begin
              // read hit answers next cycle, busy stays low
              data_out_valid <= !is_write;
            end else begin
              busy <= 1'b1;
              if (ls.dirty) begin
                state <= issue_wb;
              end else begin
                state <= issue_fill;
              end
            end
          end
        end
        issue_wb: begin
          // hold off the command while the RAM is busy
          if (!br_busy) begin
            br_cmd_en <= 1'b1;
            seq_start <= 1'b1;
            state     <= write_back;
          end
        end
        write_back: begin
          if (last) begin
            state <= issue_fill;
          end
        end
        issue_fill: begin
          if (!br_busy) begin
            br_cmd_en <= 1'b1;
            seq_start <= 1'b1;
            state     <= fill;
          end
        end
        fill: begin
          if (last) begin
            state <= finish;
          end
        end
        finish: begin
          // line is in place, read word comes out with busy falling
          data_out_valid <= !is_write;
          busy           <= 1'b0;
          state          <= idle;
        end
        default: begin
          state <= wait_ram;
        end
      endcase
    end
  end

  // command payload, only looked at together with br_cmd_en
  always_ff @(posedge clk) begin
    if (state == issue_wb) begin
      br_cmd   <= 1'b1;
      br_addr  <= wb_beat[`CACHE_RAM_ADDR_W-1:0];
      seq_read <= 1'b0;
    end else if (state == issue_fill) begin
      br_cmd   <= 1'b0;
      br_addr  <= fill_beat[`CACHE_RAM_ADDR_W-1:0];
      seq_read <= 1'b1;
    end
  end

endmodule

//--- hdl/line_store_if.sv
// line store interface
// strobes from the FSM, beat number from the sequencer, lookup results back

`timescale 1ns/1ps
`include "cache_config.svh"

interface line_store_if;
  import cache_pkg::*;

  // driven by the FSM
  logic [`CACHE_LINE_IX_W-1:0] line_ix;
  // write the incoming RAM beat at beat_ix
  logic                        fill_we;
  // merge core data into the addressed word under be
  logic                        merge_we;
  // new tag, line becomes valid and clean
  logic                        tag_we;

  // driven by the burst sequencer
  beat_ix_t                    beat_ix;

  // lookup results from the store
  logic                        hit;
  logic                        dirty;
  logic [`CACHE_TAG_W-1:0]     victim_tag;

  modport ctrl (
    output line_ix, fill_we, merge_we, tag_we,
    input  hit, dirty, victim_tag
  );

  modport seq (output beat_ix);

  modport store (
    input  line_ix, fill_we, merge_we, tag_we, beat_ix,
    output hit, dirty, victim_tag
  );

endinterface

//--- hdl/cache_pkg.sv
// shared types of the data cache
// controller states, request address views, beat number

`include "cache_config.svh"

package cache_pkg;

  // controller states
  // wait_ram is only left once the RAM stops reporting busy
  typedef enum logic [2:0] {
    wait_ram,
    idle,
    issue_wb,
    write_back,
    issue_fill,
    fill,
    finish
  } cache_state_e;

  // byte address split into lookup fields
  typedef struct packed {
    logic [`CACHE_TAG_W-1:0]     tag;
    logic [`CACHE_LINE_IX_W-1:0] line_ix;
    logic [`CACHE_WORD_IX_W-1:0] word_ix;
    logic [`CACHE_ALIGN_W-1:0]   align;
  } cache_addr_t;

  // same request word seen two ways
  // raw for RAM addressing, fields for lookup
  typedef union packed {
    logic [`CACHE_ADDR_W-1:0] raw;
    cache_addr_t              fields;
  } cache_addr_u;

  // beat number inside one burst
  typedef logic [$clog2(`CACHE_BURST_LEN)-1:0] beat_ix_t;

endpackage

//--- hdl/cache_config.svh
// geometry of the data cache and its burst RAM port
// address split, word and beat widths, line shape

`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// byte address and core word
`define CACHE_ADDR_W 32
`define CACHE_DATA_W 32
`define CACHE_BE_W 4

// burst RAM, 256 beats of 64 bits
`define CACHE_RAM_ADDR_W 8
`define CACHE_BURST_W 64
`define CACHE_BURST_LEN 4

// address split |tag|line|word|align|
// one line is one burst, 8 words
`define CACHE_LINE_IX_W 1
`define CACHE_WORD_IX_W 3
`define CACHE_ALIGN_W 2
`define CACHE_TAG_W 26

// byte address to beat address
`define CACHE_BEAT_SHIFT 3

`endif
